// File: reservation_alu1.f
+incdir+common
+incdir+bench
common/rs_types_pkg.sv
common/cdb_pkg.sv
common/cdb_if.sv
reservation_alu1/reservation_alu1_entry.sv
reservation_alu1/reservation_alu1_alloc.sv
reservation_alu1/reservation_alu1_issue.sv
reservation_alu1/reservation_alu1.sv
bench/tb_reservation_alu1.sv

// File: bench/tb_reservation_alu1_tasks.svh
`ifndef TB_RESERVATION_ALU1_TASKS_SVH
`define TB_RESERVATION_ALU1_TASKS_SVH

// xorshift32 operand source
function automatic logic [31:0] next_rand();
	rng_state ^= rng_state << 13;
	rng_state ^= rng_state >> 17;
	rng_state ^= rng_state << 5;
	return rng_state;
endfunction

// A waiting source carries the producer name in its low bits
function automatic rs_info_t make_info(input alu_cmd_e cmd, input exec_unit_e unit,
		input logic s0v, input logic [`RS_DATA_W-1:0] s0,
		input logic s1v, input logic [`RS_DATA_W-1:0] s1,
		input logic [`RS_REGNAME_W-1:0] dest);
	return '{dest[0], cmd, unit, s0v, s0, s1v, s1, dest, dest ^ 6'h2a};
endfunction

// Moves to just after the next rising edge and ends every strobe
task automatic tick();
	@(posedge iCLOCK);
	#1;
	regist_valid = 1'b0;
	remove_valid = 1'b0;
	cdb_valid = '0;
endtask

task automatic load_regist(input rs_info_t info);
	regist_writeback = info.writeback;
	regist_cmd = info.cmd;
	regist_unit = info.unit;
	regist_source0_valid = info.source0_valid;
	regist_source0 = info.source0;
	regist_source1_valid = info.source1_valid;
	regist_source1 = info.source1;
	regist_destination = info.destination;
	regist_commit_tag = info.commit_tag;
endtask

task automatic register_instr(input rs_info_t info);
	load_regist(info);
	regist_valid = 1'b1;
	tick();
endtask

// Strobe lasts until the next tick
task automatic drive_cdb(input cdb_sel_e sel, input logic wb,
		input logic [`RS_REGNAME_W-1:0] dest, input logic [`RS_DATA_W-1:0] data);
	cdb_valid[sel] = 1'b1;
	cdb_writeback[sel] = wb;
	cdb_destination[sel] = dest;
	cdb_data[sel] = data;
endtask

task automatic flush_all();
	remove_valid = 1'b1;
	tick();
endtask

task automatic set_lock(input logic lock);
	exout_lock = lock;
endtask

task automatic wait_issue(input string name);
	int waited;
	waited = 0;
	@(negedge iCLOCK);
	while (exout_valid !== 1'b1 && waited < ISSUE_WAIT) begin
		@(negedge iCLOCK);
		waited++;
	end
	if (exout_valid !== 1'b1) begin
		$display("%s: the instruction never issued within %0d cycles", name, ISSUE_WAIT);
		stop_on_error();
	end
endtask

task automatic check_bit(input string name, input string what, input logic exp,
		input logic act);
	if (act !== exp) begin
		$display("[FAIL] %s: %s expected %b, actual %b", name, what, exp, act);
		stop_on_error();
	end
endtask

task automatic check_info(input string name, input rs_info_t exp, input rs_info_t act);
	if (act !== exp) begin
		$display("[FAIL] %s: payload expected %h, actual %h", name, exp, act);
		stop_on_error();
	end
endtask

task automatic check_cmd(input string name, input alu_cmd_e exp, input alu_cmd_e act);
	if (act !== exp) begin
		$display("[FAIL] %s: cmd expected %s, actual %h", name, exp.name(), act);
		stop_on_error();
	end
endtask

task automatic issue_ready_on_arrival();
	rs_info_t info;
	info = make_info(ALU_ADD, UNIT_ADDER, 1'b1, next_rand(), 1'b1, next_rand(), 6'h05);
	register_instr(info);
	wait_issue("ready_at_regist");
	check_cmd("ready_at_regist", ALU_ADD, exout_cmd);
	check_info("ready_at_regist", info, sample_exout());
	tick();
	@(negedge iCLOCK);
	check_bit("ready_at_regist", "exout_valid after transfer", 1'b0, exout_valid);
	tick();
endtask

task automatic wake_by_cdb();
	rs_info_t info;
	rs_info_t exp;
	logic [`RS_DATA_W-1:0] data;
	data = next_rand();
	info = make_info(ALU_SUB, UNIT_ADDER, 1'b0, 32'h12, 1'b1, next_rand(), 6'h06);
	register_instr(info);
	// Adder result without writeback does not count
	drive_cdb(CH_ADDER, 1'b0, 6'h12, data);
	tick();
	@(negedge iCLOCK);
	check_bit("wakeup_no_wb", "exout_valid", 1'b0, exout_valid);
	tick();
	drive_cdb(CH_ADDER, 1'b1, 6'h12, data);
	tick();
	exp = info;
	exp.source0_valid = 1'b1;
	exp.source0 = data;
	wait_issue("wakeup_adder");
	check_info("wakeup_adder", exp, sample_exout());
	tick();
	data = next_rand();
	info = make_info(ALU_AND, UNIT_LOGIC, 1'b1, next_rand(), 1'b0, 32'h21, 6'h07);
	register_instr(info);
	drive_cdb(CH_LDST, 1'b0, 6'h21, data);
	tick();
	exp = info;
	exp.source1_valid = 1'b1;
	exp.source1 = data;
	wait_issue("wakeup_ldst");
	check_info("wakeup_ldst", exp, sample_exout());
	tick();
endtask

task automatic bypass_on_regist();
	rs_info_t info;
	rs_info_t exp;
	logic [`RS_DATA_W-1:0] d0;
	logic [`RS_DATA_W-1:0] d1;
	d0 = next_rand();
	d1 = next_rand();
	info = make_info(ALU_OR, UNIT_LOGIC, 1'b0, 32'h2a, 1'b0, 32'h2b, 6'h08);
	// Channel 1 beats channel 2 on name 2a
	drive_cdb(CH_ADDER, 1'b1, 6'h2b, d0);
	drive_cdb(CH_MULDIV, 1'b1, 6'h2a, d1);
	drive_cdb(CH_LDST, 1'b0, 6'h2a, next_rand());
	register_instr(info);
	exp = info;
	exp.source0_valid = 1'b1;
	exp.source0 = d1;
	exp.source1_valid = 1'b1;
	exp.source1 = d0;
	wait_issue("bypass");
	check_info("bypass", exp, sample_exout());
	tick();
endtask

task automatic issue_in_age_order();
	rs_info_t exp [3];
	logic [`RS_DATA_W-1:0] data;
	data = next_rand();
	set_lock(1'b1);
	exp[0] = make_info(ALU_XOR, UNIT_LOGIC, 1'b0, 32'h33, 1'b1, next_rand(), 6'h10);
	exp[1] = make_info(ALU_SHL, UNIT_SHIFT, 1'b0, 32'h33, 1'b1, next_rand(), 6'h11);
	exp[2] = make_info(ALU_SAR, UNIT_SHIFT, 1'b0, 32'h33, 1'b1, next_rand(), 6'h12);
	for (int k = 0; k < 3; k++) begin
		register_instr(exp[k]);
		exp[k].source0_valid = 1'b1;
		exp[k].source0 = data;
	end
	drive_cdb(CH_MULDIV, 1'b1, 6'h33, data);
	tick();
	for (int k = 0; k < 3; k++) begin
		// Oldest stays on the outputs while the consumer holds back
		repeat (2) begin
			@(negedge iCLOCK);
			check_bit("age_order_locked", "exout_valid", 1'b0, exout_valid);
			check_info("age_order_locked", exp[k], sample_exout());
			tick();
		end
		set_lock(1'b0);
		wait_issue("age_order");
		check_cmd("age_order", exp[k].cmd, exout_cmd);
		check_info("age_order", exp[k], sample_exout());
		tick();
		set_lock(1'b1);
	end
	set_lock(1'b0);
endtask

task automatic flush_full_station();
	rs_info_t info;
	for (int k = 0; k < `RS_ENTRY_NUM; k++) begin
		info = make_info(ALU_MUL, UNIT_MUL, 1'b0, 32'h3c, 1'b1, next_rand(), 6'(k));
		register_instr(info);
	end
	@(negedge iCLOCK);
	check_bit("full_flush", "full", 1'b1, full);
	tick();
	flush_all();
	drive_cdb(CH_MULDIV, 1'b1, 6'h3c, next_rand());
	tick();
	@(negedge iCLOCK);
	check_bit("full_flush", "exout_valid after flush", 1'b0, exout_valid);
	check_bit("full_flush", "full after flush", 1'b0, full);
	tick();
	info = make_info(ALU_DIV, UNIT_SDIV, 1'b1, next_rand(), 1'b1, next_rand(), 6'h20);
	register_instr(info);
	wait_issue("after_flush");
	check_info("after_flush", info, sample_exout());
	tick();
endtask

`endif

// File: bench/tb_reservation_alu1.sv
`include "rs_macros.svh"

module tb_reservation_alu1;

	import rs_types_pkg::*;
	import cdb_pkg::*;

	localparam int TIMEOUT_CYCLES = 400;
	localparam int ISSUE_WAIT = 8;

	logic						iCLOCK;
	logic						inRESET;
	logic						remove_valid;
	logic						regist_valid;
	alu_cmd_e					regist_cmd;
	exec_unit_e					regist_unit;
	logic						regist_writeback;
	logic						regist_source0_valid;
	logic [`RS_DATA_W-1:0]		regist_source0;
	logic						regist_source1_valid;
	logic [`RS_DATA_W-1:0]		regist_source1;
	logic [`RS_REGNAME_W-1:0]	regist_destination;
	logic [`RS_TAG_W-1:0]		regist_commit_tag;
	logic [2:0]					cdb_valid;
	logic [2:0]					cdb_writeback;
	logic [`RS_REGNAME_W-1:0]	cdb_destination [3];
	logic [`RS_DATA_W-1:0]		cdb_data [3];
	logic						exout_lock;
	logic						full;
	logic						exout_valid;
	alu_cmd_e					exout_cmd;
	exec_unit_e					exout_unit;
	logic						exout_writeback;
	logic [`RS_DATA_W-1:0]		exout_source0;
	logic [`RS_DATA_W-1:0]		exout_source1;
	logic [`RS_REGNAME_W-1:0]	exout_destination;
	logic [`RS_TAG_W-1:0]		exout_commit_tag;
	int							cycle_count;
	logic [31:0]				rng_state;

	reservation_alu1 dut_i (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .remove_valid(remove_valid),
		.regist_valid(regist_valid), .regist_cmd(regist_cmd), .regist_unit(regist_unit),
		.regist_writeback(regist_writeback),
		.regist_source0_valid(regist_source0_valid), .regist_source0(regist_source0),
		.regist_source1_valid(regist_source1_valid), .regist_source1(regist_source1),
		.regist_destination(regist_destination), .regist_commit_tag(regist_commit_tag),
		.cdb0_valid(cdb_valid[0]), .cdb0_writeback(cdb_writeback[0]),
		.cdb0_destination(cdb_destination[0]), .cdb0_data(cdb_data[0]),
		.cdb1_valid(cdb_valid[1]), .cdb1_writeback(cdb_writeback[1]),
		.cdb1_destination(cdb_destination[1]), .cdb1_data(cdb_data[1]),
		.cdb2_valid(cdb_valid[2]),
		.cdb2_destination(cdb_destination[2]), .cdb2_data(cdb_data[2]),
		.exout_lock(exout_lock), .full(full), .exout_valid(exout_valid),
		.exout_cmd(exout_cmd), .exout_unit(exout_unit), .exout_writeback(exout_writeback),
		.exout_source0(exout_source0), .exout_source1(exout_source1),
		.exout_destination(exout_destination), .exout_commit_tag(exout_commit_tag)
	);

	always #10 iCLOCK = ~iCLOCK;

	always @(posedge iCLOCK) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not complete within %0d cycles", TIMEOUT_CYCLES);
			stop_on_error();
		end
	end

	task automatic stop_on_error();
		$display("Verification failed");
		$fatal(1);
	endtask

	// Source valid flags are not on the port list
	function automatic rs_info_t sample_exout();
		return '{exout_writeback, exout_cmd, exout_unit,
			dut_i.exout_info.source0_valid, exout_source0,
			dut_i.exout_info.source1_valid, exout_source1,
			exout_destination, exout_commit_tag};
	endfunction

	`include "tb_reservation_alu1_tasks.svh"

	initial begin
		iCLOCK = 1'b0;
		inRESET = 1'b0;
		remove_valid = 1'b0;
		regist_valid = 1'b0;
		load_regist('0);
		cdb_valid = '0;
		cdb_writeback = '0;
		for (int i = 0; i < 3; i++) begin
			cdb_destination[i] = '0;
			cdb_data[i] = '0;
		end
		exout_lock = 1'b0;
		cycle_count = 0;
		rng_state = 32'd1374;
		repeat (2) @(posedge iCLOCK);
		#1;
		inRESET = 1'b1;
		@(negedge iCLOCK);
		check_bit("reset", "full", 1'b0, full);
		check_bit("reset", "exout_valid", 1'b0, exout_valid);
		tick();
		issue_ready_on_arrival();
		wake_by_cdb();
		bypass_on_regist();
		issue_in_age_order();
		flush_full_station();
		$display("Verification passed");
		$finish;
	end

endmodule

// File: reservation_alu1/reservation_alu1.sv
`include "rs_macros.svh"

module reservation_alu1 (
	input  logic						iCLOCK,
	input  logic						inRESET,
	input  logic						remove_valid,
	input  logic						regist_valid,
	input  rs_types_pkg::alu_cmd_e		regist_cmd,
	input  rs_types_pkg::exec_unit_e	regist_unit,
	input  logic						regist_writeback,
	input  logic						regist_source0_valid,
	input  logic [`RS_DATA_W-1:0]		regist_source0,
	input  logic						regist_source1_valid,
	input  logic [`RS_DATA_W-1:0]		regist_source1,
	input  logic [`RS_REGNAME_W-1:0]	regist_destination,
	input  logic [`RS_TAG_W-1:0]		regist_commit_tag,
	// CDB channel 0 from the adder
	input  logic						cdb0_valid,
	input  logic						cdb0_writeback,
	input  logic [`RS_REGNAME_W-1:0]	cdb0_destination,
	input  logic [`RS_DATA_W-1:0]		cdb0_data,
	// CDB channel 1 from mul/div
	input  logic						cdb1_valid,
	input  logic						cdb1_writeback,
	input  logic [`RS_REGNAME_W-1:0]	cdb1_destination,
	input  logic [`RS_DATA_W-1:0]		cdb1_data,
	// CDB channel 2 from load/store
	input  logic						cdb2_valid,
	input  logic [`RS_REGNAME_W-1:0]	cdb2_destination,
	input  logic [`RS_DATA_W-1:0]		cdb2_data,
	input  logic						exout_lock,
	output logic						full,
	output logic						exout_valid,
	output rs_types_pkg::alu_cmd_e		exout_cmd,
	output rs_types_pkg::exec_unit_e	exout_unit,
	output logic						exout_writeback,
	output logic [`RS_DATA_W-1:0]		exout_source0,
	output logic [`RS_DATA_W-1:0]		exout_source1,
	output logic [`RS_REGNAME_W-1:0]	exout_destination,
	output logic [`RS_TAG_W-1:0]		exout_commit_tag
);

	import rs_types_pkg::*;
	import cdb_pkg::*;

	rs_info_t					regist_info;
	rs_info_t					entry_info [`RS_ENTRY_NUM];
	rs_info_t					exout_info;
	logic [`RS_ENTRY_NUM-1:0]	entry_valid;
	logic [`RS_ENTRY_NUM-1:0]	entry_ready;
	logic [`RS_ENTRY_NUM-1:0]	entry_lock;
	logic [`RS_ENTRY_NUM-1:0]	regist_sel;
	logic [`RS_ENTRY_NUM-1:0]	issue_sel;

	cdb_if cdb_i ();

	assign regist_info = '{
		writeback:		regist_writeback,
		cmd:			regist_cmd,
		unit:			regist_unit,
		source0_valid:	regist_source0_valid,
		source0:		regist_source0,
		source1_valid:	regist_source1_valid,
		source1:		regist_source1,
		destination:	regist_destination,
		commit_tag:		regist_commit_tag
	};

	assign cdb_i.ch[CH_ADDER] = '{cdb0_valid, cdb0_writeback, cdb0_destination, cdb0_data};
	assign cdb_i.ch[CH_MULDIV] = '{cdb1_valid, cdb1_writeback, cdb1_destination, cdb1_data};
	// Load/store carries no writeback bit
	assign cdb_i.ch[CH_LDST] = '{cdb2_valid, 1'b0, cdb2_destination, cdb2_data};

	for (genvar i = 0; i < `RS_ENTRY_NUM; i++) begin : g_entry
		reservation_alu1_entry entry_i (
			.iCLOCK			(iCLOCK),
			.inRESET		(inRESET),
			.remove_valid	(remove_valid),
			.regist_valid	(regist_sel[i]),
			.regist_info	(regist_info),
			.cdb			(cdb_i.entry),
			.exout_valid	(issue_sel[i]),
			.entry_valid	(entry_valid[i]),
			.entry_ready	(entry_ready[i]),
			.regist_lock	(entry_lock[i]),
			.info			(entry_info[i])
		);
	end

	reservation_alu1_alloc alloc_i (
		.entry_valid	(entry_valid),
		.entry_lock		(entry_lock),
		.regist_valid	(regist_valid),
		.regist_sel		(regist_sel),
		.full			(full)
	);

	reservation_alu1_issue issue_i (
		.iCLOCK			(iCLOCK),
		.inRESET		(inRESET),
		.remove_valid	(remove_valid),
		.exout_lock		(exout_lock),
		.regist_sel		(regist_sel),
		.entry_ready	(entry_ready),
		.entry_info		(entry_info),
		.issue_sel		(issue_sel),
		.exout_valid	(exout_valid),
		.exout_info		(exout_info)
	);

	assign exout_cmd = exout_info.cmd;
	assign exout_unit = exout_info.unit;
	assign exout_writeback = exout_info.writeback;
	assign exout_source0 = exout_info.source0;
	assign exout_source1 = exout_info.source1;
	assign exout_destination = exout_info.destination;
	assign exout_commit_tag = exout_info.commit_tag;

endmodule

// File: reservation_alu1/reservation_alu1_issue.sv
`include "rs_macros.svh"

module reservation_alu1_issue (
	input  logic						iCLOCK,
	input  logic						inRESET,
	input  logic						remove_valid,
	input  logic						exout_lock,
	input  logic [`RS_ENTRY_NUM-1:0]	regist_sel,
	input  logic [`RS_ENTRY_NUM-1:0]	entry_ready,
	input  rs_types_pkg::rs_info_t		entry_info [`RS_ENTRY_NUM],
	output logic [`RS_ENTRY_NUM-1:0]	issue_sel,
	output logic						exout_valid,
	output rs_types_pkg::rs_info_t		exout_info
);

	// older[i][j] set when entry i was registered before entry j
	logic [`RS_ENTRY_NUM-1:0]	older [`RS_ENTRY_NUM];
	logic [`RS_ENTRY_NUM-1:0]	issue_cand;

	always_ff @(posedge iCLOCK) begin
		if (!inRESET || remove_valid) begin
			for (int i = 0; i < `RS_ENTRY_NUM; i++) begin
				older[i] <= '0;
			end
		end else begin
			for (int k = 0; k < `RS_ENTRY_NUM; k++) begin
				if (regist_sel[k]) begin
					// New entry is younger than everyone
					older[k] <= '0;
					for (int j = 0; j < `RS_ENTRY_NUM; j++) begin
						if (j != k) begin
							older[j][k] <= 1'b1;
						end
					end
				end
			end
		end
	end

	// Ready entry with no older ready entry
	always_comb begin
		for (int i = 0; i < `RS_ENTRY_NUM; i++) begin
			issue_cand[i] = entry_ready[i];
			for (int j = 0; j < `RS_ENTRY_NUM; j++) begin
				if (j != i && entry_ready[j] && older[j][i]) begin
					issue_cand[i] = 1'b0;
				end
			end
		end
	end

	// Payload of the one-hot candidate holds while the consumer locks
	always_comb begin
		exout_info = '0;
		for (int i = 0; i < `RS_ENTRY_NUM; i++) begin
			if (issue_cand[i]) begin
				exout_info = entry_info[i];
			end
		end
	end

	assign exout_valid = |issue_cand && !exout_lock;

	// Release strobe only on an actual transfer
	assign issue_sel = issue_cand & {`RS_ENTRY_NUM{exout_valid}};

endmodule

// File: reservation_alu1/reservation_alu1_alloc.sv
`include "rs_macros.svh"

module reservation_alu1_alloc (
	input  logic [`RS_ENTRY_NUM-1:0]	entry_valid,
	input  logic [`RS_ENTRY_NUM-1:0]	entry_lock,
	input  logic						regist_valid,
	output logic [`RS_ENTRY_NUM-1:0]	regist_sel,
	output logic						full
);

	logic [`RS_ENTRY_NUM-1:0]	free;
	logic						found;

	// Locked slots sit out one cycle after any change
	assign free = ~(entry_valid | entry_lock);

	assign full = ~|free;

	// Lowest free index takes the registration
	always_comb begin
		regist_sel = '0;
		found = 1'b0;
		for (int i = 0; i < `RS_ENTRY_NUM; i++) begin
			if (free[i] && !found) begin
				regist_sel[i] = regist_valid;
				found = 1'b1;
			end
		end
	end

endmodule

// File: reservation_alu1/reservation_alu1_entry.sv
`include "rs_macros.svh"

module reservation_alu1_entry (
	input  logic					iCLOCK,
	input  logic					inRESET,
	input  logic					remove_valid,
	input  logic					regist_valid,
	input  rs_types_pkg::rs_info_t	regist_info,
	cdb_if.entry					cdb,
	input  logic					exout_valid,
	output logic					entry_valid,
	output logic					entry_ready,
	output logic					regist_lock,
	output rs_types_pkg::rs_info_t	info
);

	import rs_types_pkg::*;
	import cdb_pkg::*;

	rs_state_e	state;
	logic		lock;
	rs_info_t	info_q;
	rs_info_t	base;
	rs_info_t	info_next;

	// Channel counts only with writeback, except load/store
	function automatic logic cdb_hit(
		input cdb_ch_t					ch,
		input cdb_sel_e					sel,
		input logic [`RS_REGNAME_W-1:0]	name
	);
		return ch.valid && (ch.writeback || sel == CH_LDST) && ch.destination == name;
	endfunction

	// Returns {valid, value} after snooping all channels
	function automatic logic [`RS_DATA_W:0] snoop(
		input cdb_bus_t					bus,
		input logic [`RS_DATA_W:0]		src
	);
		logic [`RS_DATA_W:0] result;
		result = src;
		if (!src[`RS_DATA_W]) begin
			// Walk down so channel 0 is written last and wins
			for (int i = CDB_CH_NUM - 1; i >= 0; i--) begin
				if (cdb_hit(bus[i], cdb_sel_e'(i), src[`RS_REGNAME_W-1:0])) begin
					result = {1'b1, bus[i].data};
				end
			end
		end
		return result;
	endfunction

	// Empty slot snoops the incoming instruction, a waiting one its own copy
	assign base = (state == RS_EMPTY) ? regist_info : info_q;

	always_comb begin
		info_next = base;
		{info_next.source0_valid, info_next.source0} =
			snoop(cdb.ch, {base.source0_valid, base.source0});
		{info_next.source1_valid, info_next.source1} =
			snoop(cdb.ch, {base.source1_valid, base.source1});
	end

	always_ff @(posedge iCLOCK) begin
		if (!inRESET) begin
			state <= RS_EMPTY;
			lock <= 1'b0;
		end else if (remove_valid || exout_valid) begin
			state <= RS_EMPTY;
			lock <= 1'b1;
		end else if (state == RS_EMPTY && regist_valid) begin
			state <= RS_WAITING;
			lock <= 1'b1;
		end else begin
			lock <= 1'b0;
		end
	end

	// Payload
	always_ff @(posedge iCLOCK) begin
		if (state == RS_WAITING || regist_valid) begin
			info_q <= info_next;
		end
	end

	assign entry_valid = (state == RS_WAITING);
	assign entry_ready = (state == RS_WAITING) && info_q.source0_valid && info_q.source1_valid;
	assign regist_lock = lock;
	assign info = info_q;

endmodule

// File: common/cdb_if.sv
interface cdb_if;

	import cdb_pkg::*;

	// Three result channels with one strobe each
	cdb_bus_t ch;

	modport source (
		output ch
	);

	modport entry (
		input ch
	);

endinterface

// File: common/cdb_pkg.sv
`include "rs_macros.svh"

package cdb_pkg;

	localparam int CDB_CH_NUM = 3;

	// Lower index wins when several channels match
	typedef enum logic [1:0] {
		CH_ADDER  = 2'd0,
		CH_MULDIV = 2'd1,
		CH_LDST   = 2'd2
	} cdb_sel_e;

	typedef struct packed {
		logic							valid;
		logic							writeback;
		logic [`RS_REGNAME_W-1:0]		destination;
		logic [`RS_DATA_W-1:0]			data;
	} cdb_ch_t;

	typedef cdb_ch_t [CDB_CH_NUM-1:0] cdb_bus_t;

endpackage

// File: common/rs_types_pkg.sv
`include "rs_macros.svh"

package rs_types_pkg;

	typedef enum logic [4:0] {
		ALU_ADD = 5'h00,
		ALU_SUB = 5'h01,
		ALU_AND = 5'h02,
		ALU_OR  = 5'h03,
		ALU_XOR = 5'h04,
		ALU_SHL = 5'h05,
		ALU_SHR = 5'h06,
		ALU_SAR = 5'h07,
		ALU_MUL = 5'h08,
		ALU_DIV = 5'h09
	} alu_cmd_e;

	// One code per execution unit class
	typedef enum logic [2:0] {
		UNIT_LOGIC,
		UNIT_SHIFT,
		UNIT_ADDER,
		UNIT_MUL,
		UNIT_SDIV,
		UNIT_UDIV,
		UNIT_SYS_REG
	} exec_unit_e;

	typedef enum logic {
		RS_EMPTY,
		RS_WAITING
	} rs_state_e;

	// Invalid source keeps the producer register name in its low bits
	typedef struct packed {
		logic							writeback;
		alu_cmd_e						cmd;
		exec_unit_e						unit;
		logic							source0_valid;
		logic [`RS_DATA_W-1:0]			source0;
		logic							source1_valid;
		logic [`RS_DATA_W-1:0]			source1;
		logic [`RS_REGNAME_W-1:0]		destination;
		logic [`RS_TAG_W-1:0]			commit_tag;
	} rs_info_t;

endpackage

// File: common/rs_macros.svh
`ifndef RS_MACROS_SVH
`define RS_MACROS_SVH

// Station depth
`define RS_ENTRY_NUM	4

// Operand width
`define RS_DATA_W		32

// Physical register name and commit tag widths
`define RS_REGNAME_W	6
`define RS_TAG_W		6

`endif
